// File: lcd_asserts.sv
`timescale 1ns/1ps

module lcd_asserts (
	input logic       clk,
	input logic       rst,
	input logic [1:0] state,
	input logic       e,
	input logic       busy,
	input logic [7:0] lcd_data
);

	logic e_pulsed;    // e went high in the current transaction

	always_ff @(posedge clk) begin
		if (rst) begin
			e_pulsed <= 1'b0;
		end else if (state == lcd_pkg::ST_IDLE) begin
			e_pulsed <= 1'b0;
		end else if (state == lcd_pkg::ST_XFER && e) begin
			e_pulsed <= 1'b1;
		end
	end

	e_only_when_active: assert property (
		@(posedge clk) disable iff (rst)
		e |-> (state == lcd_pkg::ST_INIT || state == lcd_pkg::ST_XFER)
	) else $error("e is high outside the init and transaction states");

	// the enable pulse must be complete by the time busy drops
	e_pulse_before_idle: assert property (
		@(posedge clk) disable iff (rst)
		($fell(busy) && $past(state) == lcd_pkg::ST_XFER) |-> (e_pulsed && !e)
	) else $error("busy fell before the enable pulse of the transaction finished");

	data_stable_while_e: assert property (
		@(posedge clk) disable iff (rst)
		(e && $past(e)) |-> $stable(lcd_data)
	) else $error("lcd_data changed while e was high");

endmodule

bind lcd_driver lcd_asserts i_asserts (
	.clk      (clk),
	.rst      (rst),
	.state    (state),
	.e        (e),
	.busy     (busy),
	.lcd_data (lcd_data)
);

// File: lcd_driver.sv
`timescale 1ns/1ps

module lcd_driver (
	input  logic       clk,
	input  logic       rst,
	input  logic [6:0] cfg,
	lcd_if.device      bus,
	output logic       e,
	output logic [7:0] lcd_data,
	output logic       rs,
	output logic       rw
);

	logic [1:0]                   state;
	logic [lcd_pkg::CNT_BITS-1:0] cnt;
	logic [lcd_pkg::CNT_BITS-1:0] cnt_nxt;
	logic [lcd_pkg::CNT_BITS-1:0] init_idx;
	logic                         busy;
	logic [7:0]                   fs_byte;
	logic [7:0]                   dc_byte;
	logic [7:0]                   ent_byte;
	logic [7:0]                   init_byte;
	logic                         init_e;
	logic                         xfer_e;

	assign cnt_nxt = cnt + 1'b1;
	assign bus.busy = busy;

	// outputs are registered, so decode the index of the cycle they will show in
	assign init_idx = (state == lcd_pkg::ST_PWRUP) ? '0 : cnt_nxt;

	// in a transaction cnt counts cycles since start
	assign xfer_e = (cnt_nxt >= lcd_pkg::C_E_SETUP) && (cnt_nxt < lcd_pkg::C_E_END);

	always_comb begin
		fs_byte     = lcd_pkg::CMD_FUNCTION_SET;
		fs_byte[3]  = cfg[lcd_pkg::CFG_LINES];
		fs_byte[2]  = cfg[lcd_pkg::CFG_FONT];
		dc_byte     = lcd_pkg::CMD_DISPLAY_CTRL;
		dc_byte[2]  = cfg[lcd_pkg::CFG_DISPLAY];
		dc_byte[1]  = cfg[lcd_pkg::CFG_CURSOR];
		dc_byte[0]  = cfg[lcd_pkg::CFG_BLINK];
		ent_byte    = lcd_pkg::CMD_ENTRY_MODE;
		ent_byte[1] = cfg[lcd_pkg::CFG_INC];
		ent_byte[0] = cfg[lcd_pkg::CFG_SHIFT];
	end

	// each init gap runs until the next command starts
	always_comb begin
		init_e = 1'b1;
		if (init_idx < lcd_pkg::C_INIT_E) begin
			init_byte = fs_byte;
		end else if (init_idx >= lcd_pkg::C_INIT_DC &&
				init_idx < lcd_pkg::C_INIT_DC + lcd_pkg::C_INIT_E) begin
			init_byte = dc_byte;
		end else if (init_idx >= lcd_pkg::C_INIT_CLR &&
				init_idx < lcd_pkg::C_INIT_CLR + lcd_pkg::C_INIT_E) begin
			init_byte = lcd_pkg::CMD_CLEAR;
		end else if (init_idx >= lcd_pkg::C_INIT_ENT &&
				init_idx < lcd_pkg::C_INIT_ENT + lcd_pkg::C_INIT_E) begin
			init_byte = ent_byte;
		end else begin
			init_e    = 1'b0;                 // wait gap
			init_byte = 8'h00;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state    <= lcd_pkg::ST_PWRUP;
			cnt      <= '0;
			busy     <= 1'b1;
			e        <= 1'b0;
			lcd_data <= 8'h00;
			rs       <= 1'b0;
			rw       <= 1'b0;
		end else begin
			case (state)
				lcd_pkg::ST_PWRUP: begin
					if (cnt_nxt == lcd_pkg::C_POWERUP) begin
						state    <= lcd_pkg::ST_INIT;
						cnt      <= '0;
						e        <= init_e;       // first function set cycle
						lcd_data <= init_byte;
					end else begin
						cnt <= cnt_nxt;
					end
				end
				lcd_pkg::ST_INIT: begin
					e        <= init_e;
					lcd_data <= init_byte;
					cnt      <= cnt_nxt;
					if (cnt_nxt == lcd_pkg::C_INIT_END) begin
						state <= lcd_pkg::ST_IDLE;
						cnt   <= '0;
						busy  <= 1'b0;             // ready for transactions
					end
				end
				lcd_pkg::ST_IDLE: begin
					if (bus.start) begin
						state    <= lcd_pkg::ST_XFER;
						cnt      <= lcd_pkg::CNT_BITS'(1);
						busy     <= 1'b1;
						rs       <= bus.rs;       // latch in the start cycle
						rw       <= bus.rw;
						lcd_data <= bus.data;
					end else begin
						rs       <= 1'b0;
						rw       <= 1'b0;
						lcd_data <= 8'h00;
					end
				end
				lcd_pkg::ST_XFER: begin
					cnt <= cnt_nxt;
					e   <= xfer_e;
					if (cnt_nxt == lcd_pkg::C_CMD) begin
						state    <= lcd_pkg::ST_IDLE;
						cnt      <= '0;
						busy     <= 1'b0;
						e        <= 1'b0;
						rs       <= 1'b0;
						rw       <= 1'b0;
						lcd_data <= 8'h00;
					end
				end
				default: begin
					state <= lcd_pkg::ST_PWRUP;
					cnt   <= '0;
				end
			endcase
		end
	end

endmodule

// File: lcd_if.sv
`timescale 1ns/1ps

// one LCD bus transaction from the text writer to the driver
interface lcd_if;

	logic       start;    // single-cycle strobe sent only while busy is low
	logic       rs;       // 0 command, 1 data
	logic       rw;
	logic [7:0] data;
	logic       busy;     // rises the cycle after start

	modport client (
		output start,
		output rs,
		output rw,
		output data,
		input  busy
	);

	modport device (
		input  start,
		input  rs,
		input  rw,
		input  data,
		output busy
	);

endinterface

// File: lcd_patterns.txt
# I cfg : display configuration in hex, bits lines font display cursor blink inc shift
# P gap row col char ovf : gap in idle cycles (decimal), other fields hex, ovf 1 = dropped
I 5e
P 20 0 3 48 0
P 600 1 0 41 0
P 0 1 1 42 0
P 0 1 2 43 0
P 0 1 f 44 0
P 2200 0 0 61 0
P 0 0 1 62 0
P 0 0 2 63 0
P 0 0 3 64 0
P 0 0 4 78 1
P 0 0 5 79 1
P 400 1 8 31 0
P 0 1 9 32 1
P 3000 0 f 7e 0

// File: lcd_pkg.sv
package lcd_pkg;

	localparam int CLK_PER_US   = 5;
	localparam int CNT_BITS     = 12;     // covers the 500 us power-up
	localparam int T_POWERUP_US = 500;
	localparam int T_CMD_US     = 50;
	localparam int T_CLEAR_US   = 200;
	localparam int T_ENTRY_US   = 100;
	localparam int T_E_SETUP_US = 1;
	localparam int T_E_HIGH_US  = 13;
	localparam int T_INIT_E_US  = 10;

	// delays in clock cycles
	localparam logic [CNT_BITS-1:0] C_POWERUP  = CNT_BITS'(T_POWERUP_US * CLK_PER_US);
	localparam logic [CNT_BITS-1:0] C_CMD      = CNT_BITS'(T_CMD_US * CLK_PER_US);
	localparam logic [CNT_BITS-1:0] C_E_SETUP  = CNT_BITS'(T_E_SETUP_US * CLK_PER_US);
	localparam logic [CNT_BITS-1:0] C_E_END    =
		CNT_BITS'((T_E_SETUP_US + T_E_HIGH_US) * CLK_PER_US);
	localparam logic [CNT_BITS-1:0] C_INIT_E   = CNT_BITS'(T_INIT_E_US * CLK_PER_US);
	localparam logic [CNT_BITS-1:0] C_INIT_DC  = CNT_BITS'(T_CMD_US * CLK_PER_US);
	localparam logic [CNT_BITS-1:0] C_INIT_CLR = CNT_BITS'(2 * T_CMD_US * CLK_PER_US);
	localparam logic [CNT_BITS-1:0] C_INIT_ENT =
		CNT_BITS'((2 * T_CMD_US + T_CLEAR_US) * CLK_PER_US);
	localparam logic [CNT_BITS-1:0] C_INIT_END =
		CNT_BITS'((2 * T_CMD_US + T_CLEAR_US + T_ENTRY_US) * CLK_PER_US);

	// cfg word bit positions
	localparam int CFG_LINES   = 6;
	localparam int CFG_FONT    = 5;
	localparam int CFG_DISPLAY = 4;
	localparam int CFG_CURSOR  = 3;
	localparam int CFG_BLINK   = 2;
	localparam int CFG_INC     = 1;
	localparam int CFG_SHIFT   = 0;

	localparam logic [7:0] CMD_FUNCTION_SET = 8'h30;
	localparam logic [7:0] CMD_DISPLAY_CTRL = 8'h08;
	localparam logic [7:0] CMD_CLEAR        = 8'h01;
	localparam logic [7:0] CMD_ENTRY_MODE   = 8'h04;
	localparam logic [7:0] CMD_SET_DDRAM    = 8'h80;
	localparam logic [7:0] ROW2_BASE        = 8'h40;

	localparam int QUEUE_DEPTH = 4;
	localparam int PTR_BITS    = 2;       // log2 of QUEUE_DEPTH
	localparam int QCNT_BITS   = 3;       // holds 0 to QUEUE_DEPTH

	// driver states
	localparam logic [1:0] ST_PWRUP = 2'd0;
	localparam logic [1:0] ST_INIT  = 2'd1;
	localparam logic [1:0] ST_IDLE  = 2'd2;
	localparam logic [1:0] ST_XFER  = 2'd3;

endpackage

// File: lcd_tb.sv
`timescale 1ns/1ps

module lcd_tb;

	logic       clk;
	logic       rst;
	logic [6:0] cfg;
	logic       put;
	logic       row;
	logic [3:0] col;
	logic [7:0] char_code;
	logic       e;
	logic [7:0] lcd_data;
	logic       rs;
	logic       rw;
	logic       ready;
	logic       overflow;

	int         put_gap[$];       // put records from the pattern file
	logic       put_row[$];
	logic [3:0] put_col[$];
	logic [7:0] put_char[$];
	logic       put_ovf[$];

	logic [7:0] cap_data[$];      // one entry per falling edge of e
	logic       cap_rs[$];
	logic       cap_rw[$];
	logic [7:0] held_data;
	logic       held_rs;
	logic       held_rw;
	logic       e_prev;
	logic       ready_prev;

	int   byte_errors;
	int   flag_errors;
	int   other_errors;
	int   seed;
	logic ovf_pending;            // overflow expected in the next cycle
	logic run_ok;

	lcd_top i_dut (
		.clk       (clk),
		.rst       (rst),
		.cfg       (cfg),
		.put       (put),
		.row       (row),
		.col       (col),
		.char_code (char_code),
		.e         (e),
		.lcd_data  (lcd_data),
		.rs        (rs),
		.rw        (rw),
		.ready     (ready),
		.overflow  (overflow)
	);

	always #4 clk = ~clk;

	function automatic logic [7:0] function_set_byte(input logic [6:0] c);
		return lcd_pkg::CMD_FUNCTION_SET |
			{4'h0, c[lcd_pkg::CFG_LINES], c[lcd_pkg::CFG_FONT], 2'b00};
	endfunction

	function automatic logic [7:0] display_ctrl_byte(input logic [6:0] c);
		return lcd_pkg::CMD_DISPLAY_CTRL |
			{5'h0, c[lcd_pkg::CFG_DISPLAY], c[lcd_pkg::CFG_CURSOR], c[lcd_pkg::CFG_BLINK]};
	endfunction

	function automatic logic [7:0] entry_mode_byte(input logic [6:0] c);
		return lcd_pkg::CMD_ENTRY_MODE | {6'h0, c[lcd_pkg::CFG_INC], c[lcd_pkg::CFG_SHIFT]};
	endfunction

	function automatic logic [7:0] ddram_addr_byte(input logic r, input logic [3:0] c);
		return lcd_pkg::CMD_SET_DDRAM + ({7'h0, r} * lcd_pkg::ROW2_BASE) + {4'h0, c};
	endfunction

	task automatic check_byte(input string name, input logic [7:0] exp_data,
			input logic exp_rs, input logic [7:0] got_data, input logic got_rs);
		if (got_data !== exp_data || got_rs !== exp_rs) begin
			byte_errors++;
			$display("Error: %s lcd_data %h rs %h, expected lcd_data %h rs %h",
				name, got_data, got_rs, exp_data, exp_rs);
		end
	endtask

	task automatic check_flag(input string name, input logic exp_val, input logic got_val);
		if (got_val !== exp_val) begin
			flag_errors++;
			$display("Error: %s %h, expected %h", name, got_val, exp_val);
		end
	endtask

	task automatic read_patterns(output logic ok);
		int         fd;
		int         n;
		int         gap;
		string      line;
		logic [6:0] c;
		logic       r;
		logic [3:0] cl;
		logic [7:0] ch;
		logic       ov;
		ok = 1'b1;
		fd = $fopen("lcd_patterns.txt", "r");
		if (fd == 0) begin
			other_errors++;
			$display("The pattern file lcd_patterns.txt could not be opened");
			ok = 1'b0;
			return;
		end
		while (!$feof(fd)) begin
			n = $fgets(line, fd);
			if (n == 0 || line.len() < 2 || line[0] == "#") begin
				continue;
			end
			if (line[0] == "I") begin
				n = $sscanf(line, "I %h", c);
				cfg = c;
			end else if (line[0] == "P") begin
				n = $sscanf(line, "P %d %h %h %h %h", gap, r, cl, ch, ov);
				n = (n == 5) ? 1 : 0;
				put_gap.push_back(gap);
				put_row.push_back(r);
				put_col.push_back(cl);
				put_char.push_back(ch);
				put_ovf.push_back(ov);
			end else begin
				n = 0;
			end
			if (n != 1) begin
				other_errors++;
				ok = 1'b0;
				$display("A pattern line could not be parsed: %s", line);
			end
		end
		$fclose(fd);
	endtask

	// e stays low through power-up and ready rises once init is over
	task automatic wait_ready(output logic ok);
		int pu_cycles;
		int ready_cycles;
		int cycles;
		pu_cycles    = lcd_pkg::T_POWERUP_US * lcd_pkg::CLK_PER_US;
		ready_cycles = pu_cycles + (2 * lcd_pkg::T_CMD_US + lcd_pkg::T_CLEAR_US
			+ lcd_pkg::T_ENTRY_US) * lcd_pkg::CLK_PER_US;
		cycles = 0;
		ok     = 1'b0;
		while (!ok && cycles < ready_cycles + 1000) begin
			@(negedge clk);
			cycles++;
			if (cycles < pu_cycles) begin
				check_flag("e during power-up", 1'b0, e);
			end else if (cycles == pu_cycles) begin
				check_flag("e at first init command", 1'b1, e);
			end
			if (ready) begin
				ok = 1'b1;
				if (cycles != ready_cycles) begin
					other_errors++;
					$display("ready rose %0d cycles after reset instead of %0d",
						cycles, ready_cycles);
				end
			end
		end
		if (!ok) begin
			other_errors++;
			$display("Timeout: ready never rose after power-up and initialization");
		end
	endtask

	task automatic idle_cycle();
		@(negedge clk);
		check_flag("overflow", ovf_pending, overflow);
		put         = 1'b0;
		ovf_pending = 1'b0;
	endtask

	task automatic put_cycle(input logic r, input logic [3:0] c, input logic [7:0] ch,
			input logic ov);
		@(negedge clk);
		check_flag("overflow", ovf_pending, overflow);
		put         = 1'b1;
		row         = r;
		col         = c;
		char_code   = ch;
		ovf_pending = ov;
	endtask

	task automatic apply_puts();
		int extra;
		for (int i = 0; i < put_gap.size(); i++) begin
			extra = 0;
			if (put_gap[i] > 0) begin
				extra = $unsigned($random(seed)) % 16;    // a new burst starts
			end
			repeat (put_gap[i] + extra) begin
				idle_cycle();
			end
			put_cycle(put_row[i], put_col[i], put_char[i], put_ovf[i]);
		end
		idle_cycle();
	endtask

	task automatic wait_drain(output logic ok);
		int cycles;
		int want;
		int limit;
		want = 4;
		foreach (put_ovf[i]) begin
			if (!put_ovf[i]) begin
				want += 2;
			end
		end
		limit  = want * 2 * lcd_pkg::T_CMD_US * lcd_pkg::CLK_PER_US + 2000;
		cycles = 0;
		ok     = 1'b0;
		while (!ok && cycles < limit) begin
			@(negedge clk);
			cycles++;
			ok = (cap_data.size() >= want) && ready;
		end
		if (!ok) begin
			other_errors++;
			$display("Timeout: the bus never went idle, %0d of %0d bytes seen",
				cap_data.size(), want);
			return;
		end
		repeat (2 * lcd_pkg::T_CMD_US * lcd_pkg::CLK_PER_US) begin
			@(negedge clk);
			check_flag("e after last request", 1'b0, e);
		end
	endtask

	task automatic compare_all();
		logic [7:0] exp_data[$];
		logic       exp_rs[$];
		int         n;
		exp_data = '{function_set_byte(cfg), display_ctrl_byte(cfg), lcd_pkg::CMD_CLEAR,
			entry_mode_byte(cfg)};
		exp_rs   = '{1'b0, 1'b0, 1'b0, 1'b0};
		foreach (put_ovf[i]) begin
			if (!put_ovf[i]) begin
				exp_data.push_back(ddram_addr_byte(put_row[i], put_col[i]));
				exp_rs.push_back(1'b0);
				exp_data.push_back(put_char[i]);
				exp_rs.push_back(1'b1);
			end
		end
		if (cap_data.size() != exp_data.size()) begin
			other_errors++;
			$display("The bus carried %0d bytes where %0d were expected",
				cap_data.size(), exp_data.size());
		end
		n = (cap_data.size() < exp_data.size()) ? cap_data.size() : exp_data.size();
		for (int i = 0; i < n; i++) begin
			check_byte($sformatf("byte %0d", i), exp_data[i], exp_rs[i], cap_data[i], cap_rs[i]);
			check_flag($sformatf("rw of byte %0d", i), 1'b0, cap_rw[i]);
		end
	endtask

	task automatic finish_run();
		$display("byte errors %0d, flag errors %0d, other errors %0d",
			byte_errors, flag_errors, other_errors);
		if (byte_errors + flag_errors + other_errors == 0) begin
			$display("All checks passed");
		end else begin
			$display("Checks failed");
		end
		$finish;
	endtask

	// bytes are held while e is high and logged once it drops
	always @(negedge clk) begin
		if (rst) begin
			e_prev     = 1'b0;
			ready_prev = 1'b0;
		end else begin
			if (e) begin
				held_data = lcd_data;
				held_rs   = rs;
				held_rw   = rw;
			end else if (e_prev) begin
				cap_data.push_back(held_data);
				cap_rs.push_back(held_rs);
				cap_rw.push_back(held_rw);
			end
			if (!e && !e_prev && ready && ready_prev) begin
				check_byte("idle bus", 8'h00, 1'b0, lcd_data, rs);
			end
			e_prev     = e;
			ready_prev = ready;
		end
	end

	initial begin
		clk          = 1'b0;
		rst          = 1'b1;
		cfg          = 7'h00;
		put          = 1'b0;
		row          = 1'b0;
		col          = 4'h0;
		char_code    = 8'h00;
		byte_errors  = 0;
		flag_errors  = 0;
		other_errors = 0;
		seed         = 4;
		ovf_pending  = 1'b0;
		read_patterns(run_ok);        // cfg must be settled before init starts
		repeat (4) @(negedge clk);
		rst = 1'b0;
		if (run_ok) begin
			wait_ready(run_ok);
		end
		if (run_ok) begin
			apply_puts();
			wait_drain(run_ok);
		end
		if (run_ok) begin
			compare_all();
		end
		finish_run();
	end

endmodule

// File: lcd_text.f
lcd_pkg.sv
lcd_if.sv
lcd_driver.sv
lcd_text_writer.sv
lcd_top.sv
lcd_asserts.sv
lcd_tb.sv

// File: lcd_text_writer.sv
`timescale 1ns/1ps

module lcd_text_writer (
	input  logic       clk,
	input  logic       rst,
	input  logic       put,
	input  logic       row,
	input  logic [3:0] col,
	input  logic [7:0] char_code,
	output logic       overflow,
	lcd_if.client      bus
);

	logic                          q_row  [lcd_pkg::QUEUE_DEPTH];
	logic [3:0]                    q_col  [lcd_pkg::QUEUE_DEPTH];
	logic [7:0]                    q_char [lcd_pkg::QUEUE_DEPTH];
	logic [lcd_pkg::PTR_BITS-1:0]  wr_ptr;
	logic [lcd_pkg::PTR_BITS-1:0]  rd_ptr;
	logic [lcd_pkg::QCNT_BITS-1:0] count;
	logic                          full;
	logic                          empty;
	logic                          push;
	logic                          pop;
	logic                          can_start;
	logic                          data_phase;    // address sent, data pending
	logic                          start_q;
	logic                          rs_q;
	logic [7:0]                    data_q;
	logic [7:0]                    addr_byte;

	assign full  = (count == lcd_pkg::QCNT_BITS'(lcd_pkg::QUEUE_DEPTH));
	assign empty = (count == '0);

	// head leaves once its data write is on the bus
	assign pop  = start_q && rs_q;
	assign push = put && (!full || pop);

	// busy is still low in our own start cycle
	assign can_start = !bus.busy && !start_q;

	assign addr_byte = lcd_pkg::CMD_SET_DDRAM
		+ (q_row[rd_ptr] ? lcd_pkg::ROW2_BASE : 8'h00)
		+ {4'h0, q_col[rd_ptr]};

	assign bus.start = start_q;
	assign bus.rs    = rs_q;
	assign bus.rw    = 1'b0;                // write only
	assign bus.data  = data_q;

	always_ff @(posedge clk) begin
		if (push) begin
			q_row[wr_ptr]  <= row;
			q_col[wr_ptr]  <= col;
			q_char[wr_ptr] <= char_code;
		end
	end

	// pointers wrap on their own since the depth is a power of two
	always_ff @(posedge clk) begin
		if (rst) begin
			wr_ptr   <= '0;
			rd_ptr   <= '0;
			count    <= '0;
			overflow <= 1'b0;
		end else begin
			overflow <= put && !push;         // dropped request
			if (push) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (pop) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			case ({push, pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			start_q    <= 1'b0;
			data_phase <= 1'b0;
		end else begin
			start_q <= 1'b0;
			if (can_start) begin
				if (data_phase) begin
					start_q    <= 1'b1;       // data write
					data_phase <= 1'b0;
				end else if (!empty) begin
					start_q    <= 1'b1;       // set DDRAM address
					data_phase <= 1'b1;
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (can_start) begin
			if (data_phase) begin
				rs_q   <= 1'b1;
				data_q <= q_char[rd_ptr];
			end else if (!empty) begin
				rs_q   <= 1'b0;
				data_q <= addr_byte;
			end
		end
	end

endmodule

// File: lcd_top.sv
`timescale 1ns/1ps

module lcd_top (
	input  logic       clk,
	input  logic       rst,
	input  logic [6:0] cfg,
	input  logic       put,
	input  logic       row,
	input  logic [3:0] col,
	input  logic [7:0] char_code,
	output logic       e,
	output logic [7:0] lcd_data,
	output logic       rs,
	output logic       rw,
	output logic       ready,
	output logic       overflow
);

	lcd_if bus ();

	lcd_text_writer u_writer (
		.clk       (clk),
		.rst       (rst),
		.put       (put),
		.row       (row),
		.col       (col),
		.char_code (char_code),
		.overflow  (overflow),
		.bus       (bus)
	);

	lcd_driver u_driver (
		.clk      (clk),
		.rst      (rst),
		.cfg      (cfg),
		.bus      (bus),
		.e        (e),
		.lcd_data (lcd_data),
		.rs       (rs),
		.rw       (rw)
	);

	assign ready = !bus.busy;             // high once init is done and bus idle

endmodule
